// File: laser_scan_top.f
+incdir+include
logic/line_scan_pkg.sv
logic/pixel_stream_if.sv
logic/point_if.sv
logic/video_frame_tracker.sv
logic/line_blur.sv
logic/laser_midpoint.sv
logic/point_table_apb.sv
logic/laser_scan_top.sv
test/laser_scan_tb.sv

// File: Bender.yml
package:
  name: laser_scan

sources:
  # package and interfaces first, then RTL bottom up
  - logic/line_scan_pkg.sv
  - logic/pixel_stream_if.sv
  - logic/point_if.sv
  - logic/video_frame_tracker.sv
  - logic/line_blur.sv
  - logic/laser_midpoint.sv
  - logic/point_table_apb.sv
  - logic/laser_scan_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/laser_scan_tb.sv

// File: include/laser_scan_model.svh
// reference model helpers for the laser scan testbench
// xorshift generator, causal line blur and midpoint rule

`ifndef LASER_SCAN_MODEL_SVH
`define LASER_SCAN_MODEL_SVH

// 32 bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// one causal 1-2-1 pass, negative indices take p[0]
function automatic void model_blur(ref logic [7:0] px []);
   logic [7:0] src [];
   int         sum;
   int         km1;
   int         km2;
   src = px;
   foreach (px[k]) begin
      km1   = (k >= 1) ? k - 1 : 0;
      km2   = (k >= 2) ? k - 2 : 0;
      // weights 1 2 1 over p[k-2], p[k-1], p[k], then quarter and truncate
      sum   = int'(src[km2]) + 2 * int'(src[km1]) + int'(src[k]);
      px[k] = 8'(sum / 4);
   end
endfunction

// midpoint of the lit span, zero when nothing is lit
function automatic void model_midpoint(input logic [7:0] px [], input logic [7:0] thresh,
                                       output logic found, output logic [10:0] col);
   int first;
   int last;
   first = -1;
   last  = -1;
   foreach (px[k]) begin
      if (px[k] >= thresh) begin
         if (first < 0) begin
            first = k;
         end
         last = k;
      end
   end
   found = (first >= 0);
   col   = found ? 11'((first + last) / 2) : 11'd0;
endfunction

// full chain for one line, three blurs then the midpoint rule
function automatic void model_line(input logic [7:0] px [], input logic [7:0] thresh,
                                   output logic found, output logic [10:0] col);
   logic [7:0] work [];
   work = px;
   model_blur(work);
   model_blur(work);
   model_blur(work);
   model_midpoint(work, thresh, found, col);
endfunction

`endif

// File: test/laser_scan_tb.sv
// laser scan testbench
// random frames through the DUT, point table checked against a line model

`timescale 1ns/1ps

module laser_scan_tb;
   import line_scan_pkg::*;

   `include "laser_scan_model.svh"

   localparam int CLK_PERIOD = 20;
   localparam int NUM_FRAMES = 4;
   localparam int LINES      = 24;
   localparam int PIXELS     = 64;
   // dv gap cycles allowed inside one line
   localparam int GAP_BUDGET = 8;
   localparam int HBLANK     = 6;
   localparam int VBLANK     = 8;
   localparam int STRIPE_MIN = 201;
   localparam int STRIPE_MAX = 250;
   localparam int POLL_LIMIT = 20;
   localparam int WATCHDOG_NS = NUM_FRAMES * LINES * 100 * CLK_PERIOD + 100000;

   logic      clk;
   logic      reset;
   pixel_t    pix_in;
   logic      dv;
   logic      f;
   logic      v;
   logic      h;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   logic [31:0] rng;
   int          value_errors;
   int          bus_errors;
   int          lines_sent;
   // pixels of the frame in flight, kept for the model
   pixel_t      frame_px [LINES][PIXELS];
   logic        has_stripe [LINES];
   logic [7:0]  line_buf [];

   laser_scan_top UUT (
      .clk(clk), .reset(reset), .pix_in(pix_in), .dv(dv), .f(f), .v(v), .h(h),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////
   // helpers

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // last frame sits above every stripe pixel
   function automatic pixel_t frame_thresh(input int idx);
      case (idx)
         0:       return 8'd128;
         1:       return 8'd96;
         2:       return 8'd160;
         default: return 8'd251;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                  $time, name, expected, actual);
      end
   endtask

   // setup and access phase, sampled mid access phase
   task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                             output apb_data_t rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      if (!pready) begin
         bus_errors++;
         $display("pready stayed low in the access phase to address 0x%03h", addr);
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
      apb_data_t rdata;
      logic      err;
      apb_access(1'b1, addr, data, rdata, err);
      check_value($sformatf("pslverr (write 0x%03h)", addr), 32'(exp_err), 32'(err));
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
      logic err;
      apb_access(1'b0, addr, '0, data, err);
      check_value($sformatf("pslverr (read 0x%03h)", addr), 32'(exp_err), 32'(err));
   endtask

   ////////////////////////////////////////////////////
   // video stimulus

   task automatic drive_video(input pixel_t p, input logic d, input logic vb, input logic hb);
      @(negedge clk);
      pix_in = p;
      dv     = d;
      v      = vb;
      h      = hb;
   endtask

   // dark background, most lines get a bright stripe
   task automatic make_line(input int r);
      int width;
      int start;
      int k;
      for (k = 0; k < PIXELS; k++) begin
         frame_px[r][k] = pixel_t'(next_rand() % 40);
      end
      has_stripe[r] = (next_rand() % 5) != 0;
      if (has_stripe[r]) begin
         width = 1 + int'(next_rand() % 16);
         start = int'(next_rand() % (PIXELS - width + 1));
         for (k = start; k < start + width; k++) begin
            frame_px[r][k] = pixel_t'(STRIPE_MIN + next_rand() % (STRIPE_MAX - STRIPE_MIN + 1));
         end
      end
   endtask

   task automatic send_frame(input int fidx);
      int r;
      int k;
      int gaps;
      f = fidx[0];
      // vertical blanking with h high as well
      for (k = 0; k < VBLANK; k++) begin
         drive_video(pixel_t'(next_rand()), 1'b1, 1'b1, 1'b1);
      end
      for (r = 0; r < LINES; r++) begin
         make_line(r);
         gaps = GAP_BUDGET;
         for (k = 0; k < PIXELS; k++) begin
            // dv gaps carry junk on the pixel bus
            while (gaps > 0 && next_rand() % 8 == 0) begin
               drive_video(pixel_t'(next_rand()), 1'b0, 1'b0, 1'b0);
               gaps--;
            end
            drive_video(frame_px[r][k], 1'b1, 1'b0, 1'b0);
         end
         // h rising closes the line
         for (k = 0; k < HBLANK; k++) begin
            drive_video(pixel_t'(next_rand()), 1'b1, 1'b0, 1'b1);
         end
         lines_sent++;
      end
      drive_video(8'h00, 1'b0, 1'b0, 1'b0);
   endtask

   ////////////////////////////////////////////////////
   // point table check

   task automatic check_frame(input pixel_t thresh);
      apb_data_t rdata;
      logic      exp_found;
      col_t      exp_col;
      int        polls;
      int        r;
      int        k;
      // last points trail line_end, poll the counter until they land
      polls = 0;
      do begin
         apb_read(REG_COUNT, rdata, 1'b0);
         polls++;
      end while (rdata[15:0] != 16'(lines_sent) && polls < POLL_LIMIT);
      check_value("REG_COUNT", 32'(16'(lines_sent)), rdata);
      for (r = 0; r < LINES; r++) begin
         line_buf = new[PIXELS];
         for (k = 0; k < PIXELS; k++) begin
            line_buf[k] = frame_px[r][k];
         end
         // dark line or level above the stripe, nothing is lit
         if (!has_stripe[r] || thresh > STRIPE_MAX) begin
            exp_found = 1'b0;
            exp_col   = '0;
         end else begin
            model_line(line_buf, thresh, exp_found, exp_col);
         end
         apb_read(apb_addr_t'(TABLE_BASE + 4 * r), rdata, 1'b0);
         check_value($sformatf("prdata (row %0d)", r), {exp_found, 20'd0, exp_col}, rdata);
      end
   endtask

   ////////////////////////////////////////////////////
   // main sequence

   initial begin
      apb_data_t rdata;
      int        fidx;
      rng          = 32'd4374;
      value_errors = 0;
      bus_errors   = 0;
      lines_sent   = 0;
      clk     = 1'b0;
      reset   = 1'b1;
      pix_in  = '0;
      dv      = 1'b0;
      f       = 1'b0;
      v       = 1'b0;
      h       = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (16) @(negedge clk);
      reset = 1'b0;

      // register reset values and threshold write masking
      apb_read(REG_THRESH, rdata, 1'b0);
      check_value("REG_THRESH", 32'(THRESH_RESET), rdata);
      apb_read(REG_COUNT, rdata, 1'b0);
      check_value("REG_COUNT", 32'd0, rdata);
      apb_write(REG_THRESH, 32'hABCD_12A5, 1'b0);
      apb_read(REG_THRESH, rdata, 1'b0);
      check_value("REG_THRESH", 32'h0000_00A5, rdata);

      // error responses, counter must not move
      apb_read(12'h100, rdata, 1'b1);
      apb_read(12'h7FC, rdata, 1'b1);
      apb_write(REG_COUNT, 32'h55, 1'b1);
      apb_write(apb_addr_t'(TABLE_BASE + 12), 32'h8000_0005, 1'b1);
      apb_read(REG_COUNT, rdata, 1'b0);
      check_value("REG_COUNT", 32'd0, rdata);
      // sweep still running, the last entry is not yet cleared and must read empty
      apb_read(apb_addr_t'(TABLE_BASE + 4 * (TABLE_DEPTH - 1)), rdata, 1'b0);
      check_value($sformatf("prdata (row %0d)", TABLE_DEPTH - 1), 32'd0, rdata);

      // clearing sweep takes one clock per entry
      repeat (TABLE_DEPTH + 8) @(posedge clk);

      for (fidx = 0; fidx < NUM_FRAMES; fidx++) begin
         apb_write(REG_THRESH, apb_data_t'(frame_thresh(fidx)), 1'b0);
         send_frame(fidx);
         check_frame(frame_thresh(fidx));
      end
      apb_read(REG_COUNT, rdata, 1'b0);
      check_value("REG_COUNT", NUM_FRAMES * LINES, rdata);

      $display("checks done: %0d value errors, %0d bus errors", value_errors, bus_errors);
      if (value_errors == 0 && bus_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // run length bound from the frame size
   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: logic/laser_scan_top.sv
// laser line scan top level
// frame tracker, three blur stages, midpoint finder and APB point table
// line_end at the inputs reaches the point table five clocks later

`timescale 1ns/1ps

module laser_scan_top (
   input  logic                     clk,
   input  logic                     reset,
   // decoded luma with framing
   input  line_scan_pkg::pixel_t    pix_in,
   input  logic                     dv,
   input  logic                     f,
   input  logic                     v,
   input  logic                     h,
   // APB slave
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  line_scan_pkg::apb_addr_t paddr,
   input  line_scan_pkg::apb_data_t pwdata,
   output line_scan_pkg::apb_data_t prdata,
   output logic                     pready,
   output logic                     pslverr
);
   import line_scan_pkg::*;

   // level from the APB register into the finder
   pixel_t threshold;

   ////////////////////////////////////////////////////
   // stream links

   pixel_stream_if trk_s ();
   pixel_stream_if blur1_s ();
   pixel_stream_if blur2_s ();
   pixel_stream_if blur3_s ();
   point_if        pt_s ();

   video_frame_tracker tracker (
      .clk    (clk),
      .reset  (reset),
      .pix_in (pix_in),
      .dv     (dv),
      .f      (f),
      .v      (v),
      .h      (h),
      .out    (trk_s)
   );

   // three passes for noise removal
   line_blur blur1 (.clk(clk), .reset(reset), .up(trk_s),   .down(blur1_s));
   line_blur blur2 (.clk(clk), .reset(reset), .up(blur1_s), .down(blur2_s));
   line_blur blur3 (.clk(clk), .reset(reset), .up(blur2_s), .down(blur3_s));

   laser_midpoint midpoint (
      .clk       (clk),
      .reset     (reset),
      .threshold (threshold),
      .up        (blur3_s),
      .pt        (pt_s)
   );

   point_table_apb point_table (
      .clk       (clk),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .threshold (threshold),
      .pt        (pt_s)
   );

endmodule

// File: logic/point_table_apb.sv
// point table with APB access
// threshold register, wrapping point counter and one entry per row
// zero-wait-state slave, reads are combinational

`timescale 1ns/1ps

module point_table_apb (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  line_scan_pkg::apb_addr_t paddr,
   input  line_scan_pkg::apb_data_t pwdata,
   output line_scan_pkg::apb_data_t prdata,
   output logic                     pready,
   output logic                     pslverr,
   output line_scan_pkg::pixel_t    threshold,
   point_if.sink                    pt
);
   import line_scan_pkg::*;

   // entry is {found, col}
   logic [$bits(col_t):0] table_mem [TABLE_DEPTH];
   logic [$bits(col_t):0] rd_entry;
   logic [TABLE_ADDR_W-1:0] rd_idx;
   logic [TABLE_ADDR_W-1:0] clr_addr;
   // sweep writing zeros after reset
   logic clearing;
   point_count_t point_count;

   logic access;
   logic hit_thresh;
   logic hit_count;
   logic hit_table;

   ////////////////////////////////////////////////////
   // address decode

   assign access     = psel & penable;
   assign hit_thresh = (paddr == REG_THRESH);
   assign hit_count  = (paddr == REG_COUNT);
   // window end lies past the 12 bit address space, compare in 32 bits
   assign hit_table  = (32'(paddr) >= 32'(TABLE_BASE)) &&
                       (32'(paddr) < 32'(TABLE_BASE) + 4 * TABLE_DEPTH);
   assign rd_idx     = paddr[2 +: TABLE_ADDR_W];

   // entries not yet swept read as empty
   assign rd_entry = clearing ? '0 : table_mem[rd_idx];

   // no wait states
   assign pready  = access;
   // unmapped address, or a write anywhere but the threshold
   assign pslverr = access & (~(hit_thresh | hit_count | hit_table) |
                              (pwrite & ~hit_thresh));

   always_comb begin
      prdata = '0;
      if (hit_thresh) begin
         prdata = apb_data_t'(threshold);
      end else if (hit_count) begin
         prdata = apb_data_t'(point_count);
      end else if (hit_table) begin
         prdata[31]                = rd_entry[$bits(col_t)];
         prdata[$bits(col_t)-1:0]  = rd_entry[$bits(col_t)-1:0];
      end
   end

   ////////////////////////////////////////////////////
   // table storage

   // a point always wins the single write port over the sweep
   always_ff @(posedge clk) begin
      if (pt.we) begin
         table_mem[pt.row[TABLE_ADDR_W-1:0]] <= {pt.found, pt.col};
      end else if (clearing) begin
         table_mem[clr_addr] <= '0;
      end
   end

   ////////////////////////////////////////////////////
   // registers and sweep control

   always_ff @(posedge clk) begin
      if (reset) begin
         clearing    <= 1'b1;
         clr_addr    <= '0;
         point_count <= '0;
         threshold   <= THRESH_RESET;
      end else begin
         // sweep stalls on a cycle taken by a point write
         if (clearing && !pt.we) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == TABLE_ADDR_W'(TABLE_DEPTH - 1)) begin
               clearing <= 1'b0;
            end
         end

         if (pt.we) begin
            point_count <= point_count + 1'b1;
         end

         // level in bits 7:0, upper write bits dropped
         if (access && pwrite && hit_thresh) begin
            threshold <= pwdata[7:0];
         end
      end
   end

endmodule

// File: logic/laser_midpoint.sv
// laser midpoint finder
// thresholds the blurred line, tracks first and last lit columns
// and reports their midpoint one clock after line_end

`timescale 1ns/1ps

module laser_midpoint (
   input  logic                  clk,
   input  logic                  reset,
   input  line_scan_pkg::pixel_t threshold,
   pixel_stream_if.sink          up,
   point_if.source               pt
);
   import line_scan_pkg::*;

   // column of the next pixel
   col_t col_cnt;
   // column of the pixel on the bus now
   col_t cur_col;
   col_t first_col;
   col_t last_col;
   // something lit so far on this line
   logic any_lit;
   logic any_now;
   logic lit;
   // one extra bit so first + last cannot overflow
   logic [$bits(col_t):0] span_sum;

   // line start restarts column count and lit tracking
   assign cur_col  = up.line_start ? '0 : col_cnt;
   assign any_now  = up.line_start ? 1'b0 : any_lit;
   // lit means at or above the level
   assign lit      = up.valid && (up.pixel >= threshold);
   assign span_sum = {1'b0, first_col} + {1'b0, last_col};

   ////////////////////////////////////////////////////
   // line tracking

   always_ff @(posedge clk) begin
      if (reset) begin
         col_cnt <= '0;
         any_lit <= 1'b0;
         pt.we   <= 1'b0;
      end else begin
         if (up.valid) begin
            col_cnt <= col_t'(cur_col + 1'b1);
            any_lit <= any_now | lit;
         end
         // one write per line, a clock after line_end
         pt.we <= up.line_end;
      end
   end

   always_ff @(posedge clk) begin
      if (lit) begin
         if (!any_now) begin
            first_col <= cur_col;
         end
         last_col <= cur_col;
      end

      // row still holds this line's index during line_end
      if (up.line_end) begin
         pt.row   <= up.row;
         pt.found <= any_lit;
         // truncating midpoint, zero for a dark line
         pt.col   <= any_lit ? span_sum[$bits(col_t):1] : '0;
      end
   end

endmodule

// File: logic/line_blur.sv
// causal 1-2-1 horizontal blur stage
// out = (p[k-2] + 2*p[k-1] + p[k]) / 4, first pixel replicated at line start
// one clock of latency on pixel, markers and row

`timescale 1ns/1ps

module line_blur (
   input  logic           clk,
   input  logic           reset,
   pixel_stream_if.sink   up,
   pixel_stream_if.source down
);
   import line_scan_pkg::*;

   // p[k-1] and p[k-2] of the current line
   pixel_t prev1;
   pixel_t prev2;
   // taps after edge replication
   pixel_t tap1;
   pixel_t tap2;
   // 255 * 4 needs ten bits
   logic [9:0] sum;

   // at line start both history taps take the current pixel
   assign tap1 = up.line_start ? up.pixel : prev1;
   assign tap2 = up.line_start ? up.pixel : prev2;
   assign sum  = {2'b00, tap2} + {1'b0, tap1, 1'b0} + {2'b00, up.pixel};

   ////////////////////////////////////////////////////
   // datapath

   always_ff @(posedge clk) begin
      // history only moves on real pixels, dv gaps hold it
      if (up.valid) begin
         prev2 <= tap1;
         prev1 <= up.pixel;
      end
      // truncating divide by four
      down.pixel <= sum[9:2];
      down.row   <= up.row;
   end

   ////////////////////////////////////////////////////
   // markers

   always_ff @(posedge clk) begin
      if (reset) begin
         down.valid       <= 1'b0;
         down.line_start  <= 1'b0;
         down.line_end    <= 1'b0;
         down.frame_start <= 1'b0;
      end else begin
         down.valid       <= up.valid;
         down.line_start  <= up.line_start;
         down.line_end    <= up.line_end;
         down.frame_start <= up.frame_start;
      end
   end

endmodule

// File: logic/video_frame_tracker.sv
// video frame tracker
// turns decoder f/v/h/dv framing into a marked pixel stream
// with line and frame markers and a running row index

`timescale 1ns/1ps

module video_frame_tracker (
   input  logic                  clk,
   input  logic                  reset,
   input  line_scan_pkg::pixel_t pix_in,
   input  logic                  dv,
   input  logic                  f,
   input  logic                  v,
   input  logic                  h,
   pixel_stream_if.source        out
);
   import line_scan_pkg::*;

   // pixel inside the visible window
   logic active;
   // h seen since the last active pixel, next one opens a line
   logic line_open;
   // v seen since the previous line, next line restarts the frame
   logic v_seen;
   // active pixels seen since the last h
   logic in_line;
   logic first_px;
   row_t row_q;

   assign active   = dv & ~v & ~h;
   assign first_px = active & line_open;
   assign out.row  = row_q;

   ////////////////////////////////////////////////////
   // framing state and markers

   // f (field parity) plays no part in line tracking
   always_ff @(posedge clk) begin
      if (reset) begin
         line_open       <= 1'b0;
         v_seen          <= 1'b0;
         in_line         <= 1'b0;
         row_q           <= '0;
         out.valid       <= 1'b0;
         out.line_start  <= 1'b0;
         out.frame_start <= 1'b0;
         out.line_end    <= 1'b0;
      end else begin
         // h and active never coincide, neither do v and active
         line_open <= h | (line_open & ~active);
         v_seen    <= v | (v_seen & ~first_px);
         in_line   <= active | (in_line & ~h);

         out.valid       <= active;
         out.line_start  <= first_px;
         out.frame_start <= first_px & v_seen;
         // first h cycle closing a line that had pixels
         out.line_end    <= h & in_line;

         // row changes together with the line_start pixel
         if (first_px) begin
            row_q <= v_seen ? '0 : row_t'(row_q + 1'b1);
         end
      end
   end

   // pixel payload takes the same one clock as its markers
   always_ff @(posedge clk) begin
      out.pixel <= pix_in;
   end

endmodule

// File: logic/point_if.sv
// per-row laser point from the midpoint finder to the point table
// one we pulse per line

`timescale 1ns/1ps

interface point_if;
   import line_scan_pkg::*;

   logic we;
   row_t row;
   col_t col;
   // any pixel of the row above threshold
   logic found;

   modport source (output we, row, col, found);
   modport sink   (input  we, row, col, found);

endinterface

// File: logic/pixel_stream_if.sv
// marked pixel stream between pipeline stages
// one pixel per cycle at most, no back-pressure

`timescale 1ns/1ps

interface pixel_stream_if;
   import line_scan_pkg::*;

   pixel_t pixel;
   logic   valid;
   // first pixel of a line, set only with valid
   logic   line_start;
   // single non-pixel cycle after the last pixel
   logic   line_end;
   // first pixel of the first line of a frame
   logic   frame_start;
   // index of the current line
   row_t   row;

   modport source (output pixel, valid, line_start, line_end, frame_start, row);
   modport sink   (input  pixel, valid, line_start, line_end, frame_start, row);

endinterface

// File: logic/line_scan_pkg.sv
// laser scan shared definitions
// pixel, position and bus widths plus the APB register map

package line_scan_pkg;

   ////////////////////////////////////////////////////
   // data widths

   // grayscale luma sample
   typedef logic [7:0]  pixel_t;
   // column within a line, row within a frame
   typedef logic [10:0] col_t;
   typedef logic [9:0]  row_t;

   // APB bus
   typedef logic [11:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // points written since reset, wraps
   typedef logic [15:0] point_count_t;

   ////////////////////////////////////////////////////
   // point table geometry

   localparam int TABLE_DEPTH  = 512;
   // one entry per row, low row bits index the table
   localparam int TABLE_ADDR_W = 9;

   // threshold level after reset
   localparam pixel_t THRESH_RESET = 8'd128;

   ////////////////////////////////////////////////////
   // APB register map

   localparam apb_addr_t REG_THRESH = 12'h000;
   localparam apb_addr_t REG_COUNT  = 12'h004;
   // entry r lives at TABLE_BASE + 4*r
   localparam apb_addr_t TABLE_BASE = 12'h800;

endpackage
